//--- Makefile
# Verilator build and run of the EEPROM master testbench

VERILATOR ?= verilator
TOP       ?= tb_eeprom_master
LOG       ?= sim.log
SEED_ARGS ?=
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f

VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/bus_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

module bus_byte_engine (
    input  logic      CLK,
    input  logic      RESET,
    bus_cmd_if.engine bus,
    output logic      scl,
    output logic      sda_low,
    input  logic      sda_in
);
    import eeprom_pkg::*;

    logic                 active;
    bus_cmd_t             cur_cmd;
    logic [PHASE_W-1:0]   phase;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [DATA_W-1:0]    shift_q;
    logic                 nack_q;
    logic                 ack_q;
    logic                 scl_idle;
    logic                 sda_low_idle;
    logic                 scl_ph;
    logic                 sda_low_ph;
    logic                 ack_bit;
    logic                 last_bit;
    logic                 phase_end;
    logic                 sample_ph;

    assign ack_bit   = (bit_cnt == BIT_CNT_W'(DATA_W));
    assign phase_end = (phase == PHASE_W'(PHASES_PER_BIT - 1));
    assign sample_ph = (phase == PHASE_W'(2));     // middle of scl high

    always_comb
    begin
        if (cur_cmd == CMD_WRITE || cur_cmd == CMD_READ)
            last_bit = ack_bit;
        else
            last_bit = 1'b1;                        // conditions are a single bit time
    end

    // bus levels for the current phase
    always_comb
    begin
        scl_ph     = (phase == PHASE_W'(1)) || (phase == PHASE_W'(2));
        sda_low_ph = 1'b0;
        case (cur_cmd)
            CMD_START:
            begin
                // scl stays high from the idle bus, sda falls in phase 2
                scl_ph     = !phase_end;
                sda_low_ph = (phase >= PHASE_W'(2));
            end
            CMD_RESTART:
            begin
                sda_low_ph = (phase >= PHASE_W'(2)); // released in phase 0 while scl low
            end
            CMD_STOP:
            begin
                scl_ph     = (phase != '0);
                sda_low_ph = (phase < PHASE_W'(2));
            end
            CMD_WRITE:
            begin
                if (ack_bit)
                    sda_low_ph = 1'b0;               // slave drives the ack
                else
                    sda_low_ph = !shift_q[DATA_W-1];
            end
            CMD_READ:
            begin
                if (ack_bit)
                    sda_low_ph = !nack_q;
                else
                    sda_low_ph = 1'b0;
            end
            default:
            begin
                sda_low_ph = 1'b0;
            end
        endcase
    end

    // between commands the bus keeps the levels of the last phase
    assign scl     = active ? scl_ph : scl_idle;
    assign sda_low = active ? sda_low_ph : sda_low_idle;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active       <= 1'b0;
            cur_cmd      <= CMD_STOP;
            phase        <= '0;
            bit_cnt      <= '0;
            scl_idle     <= 1'b1;
            sda_low_idle <= 1'b0;
        end
        else if (!active)
        begin
            if (bus.cmd_valid)
            begin
                active  <= 1'b1;
                cur_cmd <= bus.cmd;
                phase   <= '0;
                bit_cnt <= '0;
            end
        end
        else if (phase_end)
        begin
            phase   <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit)
            begin
                active       <= 1'b0;
                scl_idle     <= scl_ph;
                sda_low_idle <= sda_low_ph;
            end
        end
        else
        begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && bus.cmd_valid)
        begin
            shift_q <= bus.tx_byte;
            nack_q  <= bus.master_nack;
        end
        else if (active && !ack_bit)
        begin
            if (cur_cmd == CMD_READ && sample_ph)
                shift_q <= {shift_q[DATA_W-2:0], sda_in};    // msb first
            else if (cur_cmd == CMD_WRITE && phase_end)
                shift_q <= {shift_q[DATA_W-2:0], 1'b0};
        end

        if (active && ack_bit && cur_cmd == CMD_WRITE && sample_ph)
            ack_q <= sda_in;
    end

    assign bus.cmd_done   = active && phase_end && last_bit;
    assign bus.rx_byte    = shift_q;
    assign bus.slave_nack = ack_q;

endmodule

`default_nettype wire

//--- hdl/bus_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bus_cmd_if;
    import eeprom_pkg::*;

    logic              cmd_valid;
    bus_cmd_t          cmd;
    logic [DATA_W-1:0] tx_byte;
    logic              master_nack;   // level sent in the ninth bit of a read
    logic              cmd_done;
    logic [DATA_W-1:0] rx_byte;
    logic              slave_nack;    // high when the line was released in the ack bit

    modport sequencer (
        output cmd_valid,
        output cmd,
        output tx_byte,
        output master_nack,
        input  cmd_done,
        input  rx_byte,
        input  slave_nack
    );

    modport engine (
        input  cmd_valid,
        input  cmd,
        input  tx_byte,
        input  master_nack,
        output cmd_done,
        output rx_byte,
        output slave_nack
    );

endinterface

`default_nettype wire

//--- hdl/eeprom_master.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_master (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          busy,
    output logic                          done,
    output logic                          nack_error,
    output logic                          scl,
    output logic                          sda_low,
    input  logic                          sda_in
);

    bus_cmd_if cmd_bus ();

    eeprom_sequencer seq0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .busy       (busy),
        .done       (done),
        .nack_error (nack_error),
        .bus        (cmd_bus.sequencer)
    );

    // open-drain line is resolved outside
    bus_byte_engine engine0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .bus     (cmd_bus.engine),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

endmodule

`default_nettype wire

//--- hdl/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W         = 11;
    localparam int DATA_W         = 8;
    localparam int BLOCK_W        = 3;                       // address bits in the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // one scl quarter period per phase
    localparam int PHASES_PER_BIT = 4;
    localparam int PHASE_W        = $clog2(PHASES_PER_BIT);
    localparam int BIT_CNT_W      = $clog2(DATA_W + 1);      // eight data bits plus ack

    typedef enum logic [2:0] {
        CMD_START   = 3'd0,
        CMD_RESTART = 3'd1,
        CMD_STOP    = 3'd2,
        CMD_WRITE   = 3'd3,
        CMD_READ    = 3'd4
    } bus_cmd_t;

    typedef enum logic [8:0] {
        IDLE    = 9'b0_0000_0001,
        START   = 9'b0_0000_0010,
        CTRL_WR = 9'b0_0000_0100,
        ADDR_WR = 9'b0_0000_1000,
        DATA_WR = 9'b0_0001_0000,
        RESTART = 9'b0_0010_0000,
        CTRL_RD = 9'b0_0100_0000,
        DATA_RD = 9'b0_1000_0000,
        STOP    = 9'b1_0000_0000
    } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          busy,
    output logic                          done,
    output logic                          nack_error,
    bus_cmd_if.sequencer                  bus
);
    import eeprom_pkg::*;

    seq_state_t        state;
    seq_state_t        state_next;
    logic              advance;
    logic              nack_seen;
    logic              is_read;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;

    function automatic logic [DATA_W-1:0] ctrl_byte(input logic [ADDR_W-1:0] a,
                                                    input logic rw);
        return {DEVICE_CODE, a[ADDR_W-1 -: BLOCK_W], rw};
    endfunction

    assign busy    = (state != IDLE);
    assign advance = (state == IDLE) ? (wr || rd) : bus.cmd_done;

    always_comb
    begin
        nack_seen = 1'b0;
        case (state)
            IDLE:    state_next = START;
            START:   state_next = CTRL_WR;
            CTRL_WR: state_next = ADDR_WR;
            ADDR_WR: state_next = is_read ? RESTART : DATA_WR;
            DATA_WR: state_next = STOP;
            RESTART: state_next = CTRL_RD;
            CTRL_RD: state_next = DATA_RD;
            DATA_RD: state_next = STOP;
            default: state_next = IDLE;
        endcase
        // refused byte abandons the transaction
        if (bus.cmd == CMD_WRITE && bus.slave_nack)
        begin
            nack_seen  = 1'b1;
            state_next = STOP;
        end
    end

    // one command per state
    always_comb
    begin
        bus.tx_byte = '0;
        case (state)
            START:
                bus.cmd = CMD_START;
            CTRL_WR:
            begin
                bus.cmd     = CMD_WRITE;
                bus.tx_byte = ctrl_byte(addr_q, 1'b0);
            end
            ADDR_WR:
            begin
                bus.cmd     = CMD_WRITE;
                bus.tx_byte = addr_q[DATA_W-1:0];
            end
            DATA_WR:
            begin
                bus.cmd     = CMD_WRITE;
                bus.tx_byte = wdata_q;
            end
            RESTART:
                bus.cmd = CMD_RESTART;
            CTRL_RD:
            begin
                bus.cmd     = CMD_WRITE;
                bus.tx_byte = ctrl_byte(addr_q, 1'b1);
            end
            DATA_RD:
                bus.cmd = CMD_READ;
            default:
                bus.cmd = CMD_STOP;
        endcase
    end

    assign bus.master_nack = (state == DATA_RD);   // single byte read ends with nack

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= IDLE;
            bus.cmd_valid <= 1'b0;
            done          <= 1'b0;
            nack_error    <= 1'b0;
        end
        else
        begin
            bus.cmd_valid <= 1'b0;
            done          <= 1'b0;
            if (advance)
            begin
                state <= state_next;
                if (state_next == IDLE)
                    done <= 1'b1;
                else
                    bus.cmd_valid <= 1'b1;
                if (state == IDLE)
                    nack_error <= 1'b0;
                else if (nack_seen)
                    nack_error <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE && (wr || rd))
        begin
            is_read <= !wr;                         // wr wins
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == DATA_RD && bus.cmd_done)
            rdata <= bus.rx_byte;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/eeprom_pkg.sv
hdl/bus_cmd_if.sv
hdl/bus_byte_engine.sv
hdl/eeprom_sequencer.sv
hdl/eeprom_master.sv
tests/eeprom_slave_model.sv
tests/eeprom_asserts.sv
tests/tb_eeprom_master.sv

//--- tests/eeprom_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_asserts (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 scl,
    input  logic                 sda_low,
    input  logic                 sda_in,
    input  logic                 active,
    input  eeprom_pkg::bus_cmd_t cur_cmd,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bus_cmd_t cmd,
    input  logic                 cmd_done
);
    import eeprom_pkg::*;

    localparam int COND_CYCLES = PHASES_PER_BIT;
    localparam int BYTE_CYCLES = 9 * PHASES_PER_BIT;     // eight data bits and the ack

    logic data_cmd;
    logic take_cond;
    logic take_byte;

    assign data_cmd  = active && (cur_cmd == CMD_WRITE || cur_cmd == CMD_READ);
    assign take_cond = cmd_valid && !active
                       && (cmd == CMD_START || cmd == CMD_RESTART || cmd == CMD_STOP);
    assign take_byte = cmd_valid && !active && (cmd == CMD_WRITE || cmd == CMD_READ);

    // only conditions may move sda with scl high
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (data_cmd && scl && $past(scl)) |-> (sda_low == $past(sda_low) && sda_in == $past(sda_in)))
        else $error("sda changed while scl was high in a byte command");

    single_done: assert property (@(posedge CLK) disable iff (RESET)
        cmd_done |=> !cmd_done)
        else $error("cmd_done high on two consecutive cycles");

    cond_latency: assert property (@(posedge CLK) disable iff (RESET)
        take_cond |-> ##COND_CYCLES cmd_done)
        else $error("condition command did not finish in one bit time");

    byte_latency: assert property (@(posedge CLK) disable iff (RESET)
        take_byte |-> ##BYTE_CYCLES cmd_done)
        else $error("byte command did not finish in nine bit times");

    idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        (!active && cur_cmd == CMD_STOP) |-> (scl && !sda_low && sda_in))
        else $error("bus not idle after a stop");

endmodule

`default_nettype wire

//--- tests/eeprom_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_slave_model (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        scl,
    input  logic        sda,
    input  logic        refuse,          // withhold the ack of a write control byte
    output logic        sda_low,
    output logic        framing_error,
    output logic [31:0] txn_count
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CTRL,
        S_ADDR,
        S_DATA,
        S_READ_PEND,
        S_READ,
        S_WAIT
    } slave_state_t;

    logic [DATA_W-1:0]  mem [0:(1 << ADDR_W)-1];
    slave_state_t       state;
    logic               scl_q;
    logic               sda_q;
    logic               in_txn;
    logic               master_nack;
    logic [3:0]         bit_cnt;
    logic [DATA_W-1:0]  sr;
    logic [DATA_W-1:0]  rd_sr;
    logic [BLOCK_W-1:0] block;
    logic [ADDR_W-1:0]  ptr;

    initial
    begin
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = DATA_W'(i ^ (i >> 3));
    end

    // line levels are sampled once per clock, edges seen one cycle late
    always @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= S_IDLE;
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            in_txn        <= 1'b0;
            bit_cnt       <= 4'd0;
            sda_low       <= 1'b0;
            framing_error <= 1'b0;
            txn_count     <= 32'd0;
            master_nack   <= 1'b1;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda)
            begin
                // a condition bit has one scl rise of its own
                if (bit_cnt > 4'd1)
                    framing_error <= 1'b1;
                in_txn  <= 1'b1;
                state   <= S_CTRL;
                bit_cnt <= 4'd0;
                sda_low <= 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                if (!in_txn || bit_cnt > 4'd1)
                    framing_error <= 1'b1;
                if (in_txn)
                    txn_count <= txn_count + 32'd1;
                in_txn  <= 1'b0;
                state   <= S_IDLE;
                bit_cnt <= 4'd0;
                sda_low <= 1'b0;
            end
            else if (scl && !scl_q && in_txn)
            begin
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt < 4'd8)
                    sr <= {sr[DATA_W-2:0], sda};
                else if (state == S_READ)
                    master_nack <= sda;
            end
            else if (!scl && scl_q && in_txn)
            begin
                if (bit_cnt == 4'd8)
                begin
                    case (state)
                        S_CTRL:
                        begin
                            if (sr[7:4] != DEVICE_CODE)
                                state <= S_WAIT;
                            else if (sr[0])
                            begin
                                state   <= S_READ_PEND;
                                sda_low <= 1'b1;
                            end
                            else if (refuse)
                                state <= S_WAIT;       // no ack, line stays high
                            else
                            begin
                                block   <= sr[3:1];
                                state   <= S_ADDR;
                                sda_low <= 1'b1;
                            end
                        end
                        S_ADDR:
                        begin
                            ptr     <= {block, sr};
                            state   <= S_DATA;
                            sda_low <= 1'b1;
                        end
                        S_DATA:
                        begin
                            mem[ptr] <= sr;
                            state    <= S_WAIT;
                            sda_low  <= 1'b1;
                        end
                        S_READ:
                            sda_low <= 1'b0;           // master owns the ack bit
                        default:
                            framing_error <= 1'b1;
                    endcase
                end
                else if (bit_cnt == 4'd9)
                begin
                    bit_cnt <= 4'd0;
                    if (state == S_READ_PEND)
                    begin
                        state   <= S_READ;
                        rd_sr   <= mem[ptr];
                        sda_low <= !mem[ptr][7];
                    end
                    else
                    begin
                        sda_low <= 1'b0;
                        if (state == S_READ)
                        begin
                            state <= S_WAIT;
                            if (!master_nack)
                                framing_error <= 1'b1;   // single byte read must end in nack
                        end
                    end
                end
                else if (state == S_READ && bit_cnt != 4'd0)
                    sda_low <= !rd_sr[3'd7 - bit_cnt[2:0]];
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_eeprom_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_master;
    import eeprom_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_PAIRS    = 24;
    localparam int N_READS    = 40;
    localparam int TXN_MAX    = 3 * N_PAIRS + N_READS;
    // four bytes and three conditions in a read, plus command and handshake cycles
    localparam int WORST_TXN  = (4 * 9 + 3) * PHASES_PER_BIT + 16;
    localparam int CYCLE_LIMIT = TXN_MAX * WORST_TXN + 200;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              busy;
    logic              done;
    logic              nack_error;
    logic              scl;
    logic              sda_low;
    logic              sda_in;
    logic              slave_low;
    logic              refuse;
    logic              framing_error;
    logic [31:0]       txn_count;

    logic [15:0]       lfsr_q;
    logic [DATA_W-1:0] shadow [0:(1 << ADDR_W)-1];
    logic [ADDR_W-1:0] written_q[$];
    logic [ADDR_W-1:0] refused_q[$];
    int                accepted;
    int                cycles;

    assign sda_in = !(sda_low || slave_low);    // wired-and of the open-drain line

    eeprom_master dut0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .busy       (busy),
        .done       (done),
        .nack_error (nack_error),
        .scl        (scl),
        .sda_low    (sda_low),
        .sda_in     (sda_in)
    );

    eeprom_slave_model slave0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda_in),
        .refuse        (refuse),
        .sda_low       (slave_low),
        .framing_error (framing_error),
        .txn_count     (txn_count)
    );

    bind bus_byte_engine eeprom_asserts asserts0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in),
        .active    (active),
        .cur_cmd   (cur_cmd),
        .cmd_valid (bus.cmd_valid),
        .cmd       (bus.cmd),
        .cmd_done  (bus.cmd_done)
    );

    always #(CLK_PERIOD / 2) CLK = !CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: the transactions did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // one host transaction, optionally with a stray strobe while busy
    task automatic run_txn(input logic is_wr, input logic [ADDR_W-1:0] a,
                           input logic [DATA_W-1:0] d, input logic refuse_it,
                           input logic extra);
        int waited;
        check_value("busy", 32'(busy), 32'd0);
        wr       = is_wr;
        rd       = !is_wr;
        addr     = a;
        wdata    = d;
        refuse   = refuse_it;
        accepted = accepted + 1;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        check_value("busy", 32'(busy), 32'd1);
        waited = 0;
        while (!done)
        begin
            if (extra && waited == 6)
            begin
                addr  = a ^ 11'h7ff;
                wdata = ~d;
                if (a[0])
                    wr = 1'b1;
                else
                    rd = 1'b1;
            end
            else
            begin
                wr = 1'b0;
                rd = 1'b0;
            end
            @(posedge CLK);
            #1;
            waited++;
        end
        check_value("busy", 32'(busy), 32'd0);
        check_value("scl", 32'(scl), 32'd1);
        check_value("sda", 32'(sda_in), 32'd1);
        check_value("framing_error", 32'(framing_error), 32'd0);
        check_value("txn_count", txn_count, 32'(accepted));
        refuse = 1'b0;
    endtask

    task automatic finish_txn();
        @(posedge CLK);
        #1;
        check_value("done", 32'(done), 32'd0);
    endtask

    task automatic do_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                            input logic refuse_it, input logic extra);
        run_txn(1'b1, a, d, refuse_it, extra);
        check_value("nack_error", 32'(nack_error), 32'(refuse_it));
        if (refuse_it)
        begin
            check_value("slave mem", 32'(slave0.mem[a]), 32'(shadow[a]));
            refused_q.push_back(a);
        end
        else
        begin
            shadow[a] = d;
            written_q.push_back(a);
        end
        finish_txn();
    endtask

    task automatic do_read(input logic [ADDR_W-1:0] a, input logic extra);
        run_txn(1'b0, a, 8'h00, 1'b0, extra);
        check_value("nack_error", 32'(nack_error), 32'd0);
        check_value("rdata", 32'(rdata), 32'(shadow[a]));
        finish_txn();
    endtask

    initial
    begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] a2;
        logic [DATA_W-1:0] d;
        logic [2:0]        blk;
        logic              ref_it;
        logic              ex;
        int                idx;

        CLK      = 1'b0;
        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wdata    = '0;
        refuse   = 1'b0;
        lfsr_q   = 16'd35856;
        accepted = 0;
        cycles   = 0;
        for (int i = 0; i < (1 << ADDR_W); i++)
            shadow[i] = DATA_W'(i ^ (i >> 3));

        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(posedge CLK);
        #1;
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("nack_error", 32'(nack_error), 32'd0);
        check_value("scl", 32'(scl), 32'd1);
        check_value("sda_low", 32'(sda_low), 32'd0);

        // each write is paired with one to the same word in another block
        for (int p = 0; p < N_PAIRS; p++)
        begin
            random_bits(ADDR_W, r);
            a = r[ADDR_W-1:0];
            random_bits(DATA_W, r);
            d = r[DATA_W-1:0];
            random_bits(3, r);
            ref_it = (r[2:0] == 3'd0) || (p == 0);   // at least one refusal
            random_bits(1, r);
            ex = r[0];
            do_write(a, d, ref_it, ex);
            random_bits(3, r);
            blk = r[2:0];
            if (blk == a[10:8])
                blk = blk + 3'd1;
            a2 = {blk, a[7:0]};
            random_bits(DATA_W, r);
            do_write(a2, r[DATA_W-1:0], 1'b0, 1'b0);
        end

        for (int i = 0; i < N_READS; i++)
        begin
            random_bits(7, r);
            idx = int'(r[6:0]) % written_q.size();
            random_bits(1, r);
            do_read(written_q[idx], r[0]);
        end

        foreach (refused_q[i])
            do_read(refused_q[i], 1'b0);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
